//--- include/rv_exec_defines.svh
`ifndef RV_EXEC_DEFINES_SVH
`define RV_EXEC_DEFINES_SVH

// Data path and pc width
`define XLEN 32

// Register file address width, x0 to x31
`define RADDR_W 5

// Sequential pc increment, also the link offset for jal and jalr
`define PC_STEP 4

// Stages between input and output: decode, execute, commit
`define PIPE_DEPTH 3

`endif

//--- hw/rv_exec_pkg.sv
package rv_exec_pkg;

    // RV32I major opcodes handled by the slice
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_NONE  // Unsupported instruction
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_e;

    // Encoded like funct3 where possible
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_NOBR = 3'b010,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_e;

endpackage

//--- hw/imm_gen.sv
`timescale 1ns/1ps
`include "rv_exec_defines.svh"

module imm_gen import rv_exec_pkg::*; (
    input  logic [`XLEN-1:0] inst,
    input  imm_fmt_e         imm_fmt,
    output logic [`XLEN-1:0] imm
);

    logic sign;

    assign sign = inst[31];  // Immediate sign is always bit 31

    always_comb begin
        case (imm_fmt)
            IMM_I: begin
                imm = {{(`XLEN-12){sign}}, inst[31:20]};
            end
            IMM_S: begin
                imm = {{(`XLEN-12){sign}}, inst[31:25], inst[11:7]};
            end
            IMM_B: begin
                // Offset in half words, bit 0 implied zero
                imm = {{(`XLEN-13){sign}}, inst[31], inst[7], inst[30:25],
                       inst[11:8], 1'b0};
            end
            IMM_U: begin
                imm = {inst[31:12], 12'b0};  // Upper 20 bits, low bits zero
            end
            IMM_J: begin
                imm = {{(`XLEN-21){sign}}, inst[31], inst[19:12], inst[20],
                       inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

//--- hw/inst_decode.sv
`timescale 1ns/1ps
`include "rv_exec_defines.svh"

module inst_decode import rv_exec_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                advance,
    input  logic                in_valid,
    input  logic [`XLEN-1:0]    inst,
    input  logic [`XLEN-1:0]    pc,
    input  logic [`XLEN-1:0]    rs1_data,
    input  logic [`XLEN-1:0]    rs2_data,
    output logic                dec_valid,
    output alu_op_e             dec_alu_op,
    output branch_e             dec_branch,
    output logic [`XLEN-1:0]    dec_opa,
    output logic [`XLEN-1:0]    dec_opb,
    output logic [`XLEN-1:0]    dec_pc,
    output logic [`XLEN-1:0]    dec_rs2,
    output logic [`RADDR_W-1:0] dec_rd,
    output logic                dec_wen,
    output logic                dec_is_jump,
    output logic                dec_supported
);

    opcode_e             opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RADDR_W-1:0] rd;
    imm_fmt_e            imm_fmt;
    logic [`XLEN-1:0]    imm;
    alu_op_e             alu_op;
    branch_e             branch;
    logic [`XLEN-1:0]    opa;
    logic [`XLEN-1:0]    opb;
    logic                wen;
    logic                is_jump;
    logic                supported;

    // funct3 selects the operation, alt picks sub and sra
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];

    // Immediate format depends on the major opcode only
    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC: imm_fmt = IMM_U;
            OPC_JAL:            imm_fmt = IMM_J;
            OPC_BRANCH:         imm_fmt = IMM_B;
            default:            imm_fmt = IMM_I;
        endcase
    end

    imm_gen imm_gen_inst (
        .inst    (inst),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    always_comb begin
        alu_op    = ALU_NONE;
        branch    = BR_NOBR;
        opa       = rs1_data;
        opb       = imm;
        wen       = 1'b0;
        is_jump   = 1'b0;
        supported = 1'b0;
        case (opcode)
            OPC_OP: begin
                if (funct7 == 7'b0000000 ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    supported = 1'b1;
                    alu_op    = alu_from_funct3(funct3, funct7[5]);
                    opb       = rs2_data;
                    wen       = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                // Shift immediates carry funct7 in the upper bits
                if ((funct3 != 3'b001 && funct3 != 3'b101) || funct7 == 7'b0000000 ||
                    (funct3 == 3'b101 && funct7 == 7'b0100000)) begin
                    supported = 1'b1;
                    alu_op    = alu_from_funct3(funct3, funct3 == 3'b101 && funct7[5]);
                    wen       = 1'b1;
                end
            end
            OPC_LUI: begin
                supported = 1'b1;
                alu_op    = ALU_ADD;
                opa       = '0;  // Result is the bare U immediate
                wen       = 1'b1;
            end
            OPC_AUIPC, OPC_JAL: begin
                supported = 1'b1;
                alu_op    = ALU_ADD;
                opa       = pc;
                wen       = 1'b1;
                is_jump   = (opcode == OPC_JAL);
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    supported = 1'b1;
                    alu_op    = ALU_ADD;
                    wen       = 1'b1;
                    is_jump   = 1'b1;
                end
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  branch = BR_BEQ;
                    3'b001:  branch = BR_BNE;
                    3'b100:  branch = BR_BLT;
                    3'b101:  branch = BR_BGE;
                    3'b110:  branch = BR_BLTU;
                    3'b111:  branch = BR_BGEU;
                    default: branch = BR_NOBR;
                endcase
                supported = (branch != BR_NOBR);
                alu_op    = supported ? ALU_ADD : ALU_NONE;  // Target adder
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (advance) begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            dec_alu_op    <= alu_op;
            dec_branch    <= branch;
            dec_opa       <= opa;
            dec_opb       <= opb;
            dec_pc        <= pc;
            dec_rs2       <= rs2_data;  // Compare value for branches
            dec_rd        <= rd;
            dec_wen       <= wen && (rd != '0);
            dec_is_jump   <= is_jump;
            dec_supported <= supported;
        end
    end

    // Execute relies on a real operation for every supported item
    a_supported_has_op: assert property (@(posedge clk) disable iff (rst)
        dec_valid && dec_supported |-> dec_alu_op != ALU_NONE);

endmodule

//--- hw/alu_execute.sv
`timescale 1ns/1ps
`include "rv_exec_defines.svh"

module alu_execute import rv_exec_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                advance,
    input  logic                dec_valid,
    input  alu_op_e             dec_alu_op,
    input  branch_e             dec_branch,
    input  logic [`XLEN-1:0]    dec_opa,
    input  logic [`XLEN-1:0]    dec_opb,
    input  logic [`XLEN-1:0]    dec_rs2,
    input  logic [`XLEN-1:0]    dec_pc,
    input  logic [`RADDR_W-1:0] dec_rd,
    input  logic                dec_wen,
    input  logic                dec_is_jump,
    input  logic                dec_supported,
    output logic                ex_valid,
    output logic [`XLEN-1:0]    ex_result,
    output logic [`XLEN-1:0]    ex_pc,
    output logic [`RADDR_W-1:0] ex_rd,
    output logic                ex_wen,
    output logic                ex_jump,
    output logic                ex_take
);

    logic [`XLEN-1:0] alu_a;
    logic [`XLEN-1:0] alu_y;
    logic [4:0]       shamt;
    logic             eq;
    logic             lt;
    logic             ltu;
    logic             cond;
    logic             take;
    logic [`XLEN-1:0] result;

    assign alu_a = (dec_branch != BR_NOBR) ? dec_pc : dec_opa;  // Branch target from pc
    assign shamt = dec_opb[4:0];

    always_comb begin
        case (dec_alu_op)
            ALU_ADD:  alu_y = alu_a + dec_opb;
            ALU_SUB:  alu_y = alu_a - dec_opb;
            ALU_SLL:  alu_y = alu_a << shamt;
            ALU_SLT:  alu_y = {{(`XLEN-1){1'b0}}, $signed(alu_a) < $signed(dec_opb)};
            ALU_SLTU: alu_y = {{(`XLEN-1){1'b0}}, alu_a < dec_opb};
            ALU_XOR:  alu_y = alu_a ^ dec_opb;
            ALU_SRL:  alu_y = alu_a >> shamt;
            ALU_SRA:  alu_y = $unsigned($signed(alu_a) >>> shamt);
            ALU_OR:   alu_y = alu_a | dec_opb;
            ALU_AND:  alu_y = alu_a & dec_opb;
            default:  alu_y = '0;
        endcase
    end

    // Branch compare is rs1 against rs2
    assign eq  = (dec_opa == dec_rs2);
    assign lt  = ($signed(dec_opa) < $signed(dec_rs2));
    assign ltu = (dec_opa < dec_rs2);

    always_comb begin
        case (dec_branch)
            BR_BEQ:  cond = eq;
            BR_BNE:  cond = !eq;
            BR_BLT:  cond = lt;
            BR_BGE:  cond = !lt;
            BR_BLTU: cond = ltu;
            BR_BGEU: cond = !ltu;
            default: cond = 1'b0;
        endcase
    end

    assign take = dec_supported && (dec_is_jump || cond);

    // jalr needs bit 0 cleared, jal targets are already even
    assign result = dec_is_jump ? {alu_y[`XLEN-1:1], 1'b0} : alu_y;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else if (advance) begin
            ex_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            ex_result <= result;
            ex_pc     <= dec_pc;
            ex_rd     <= dec_rd;
            ex_wen    <= dec_wen;
            ex_jump   <= dec_is_jump;
            ex_take   <= take;
        end
    end

endmodule

//--- hw/commit_stage.sv
`timescale 1ns/1ps
`include "rv_exec_defines.svh"

module commit_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                out_ready,
    input  logic                ex_valid,
    input  logic [`XLEN-1:0]    ex_result,
    input  logic [`XLEN-1:0]    ex_pc,
    input  logic [`RADDR_W-1:0] ex_rd,
    input  logic                ex_wen,
    input  logic                ex_jump,
    input  logic                ex_take,
    output logic                advance,
    output logic                out_valid,
    output logic [`RADDR_W-1:0] rd,
    output logic                rd_wen,
    output logic [`XLEN-1:0]    rd_data,
    output logic                branch_taken,
    output logic [`XLEN-1:0]    next_pc
);

    logic [`XLEN-1:0] link;

    assign link = ex_pc + `PC_STEP;

    // Whole pipeline moves when the output slot is free or being taken
    assign advance = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            rd           <= ex_rd;
            rd_wen       <= ex_wen;
            rd_data      <= ex_jump ? link : ex_result;  // Jumps write the link value
            branch_taken <= ex_take;
            next_pc      <= ex_take ? ex_result : link;
        end
    end

    // A stalled result must not change until it is accepted
    a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(rd) && $stable(rd_wen) &&
        $stable(rd_data) && $stable(branch_taken) && $stable(next_pc));

endmodule

//--- hw/rv_exec_unit.sv
`timescale 1ns/1ps
`include "rv_exec_defines.svh"

module rv_exec_unit import rv_exec_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [`XLEN-1:0]    inst,
    input  logic [`XLEN-1:0]    pc,
    input  logic [`XLEN-1:0]    rs1_data,
    input  logic [`XLEN-1:0]    rs2_data,
    output logic                out_valid,
    input  logic                out_ready,
    output logic [`RADDR_W-1:0] rd,
    output logic                rd_wen,
    output logic [`XLEN-1:0]    rd_data,
    output logic                branch_taken,
    output logic [`XLEN-1:0]    next_pc
);

    logic                advance;

    // Decode to execute
    logic                dec_valid;
    alu_op_e             dec_alu_op;
    branch_e             dec_branch;
    logic [`XLEN-1:0]    dec_opa;
    logic [`XLEN-1:0]    dec_opb;
    logic [`XLEN-1:0]    dec_pc;
    logic [`XLEN-1:0]    dec_rs2;
    logic [`RADDR_W-1:0] dec_rd;
    logic                dec_wen;
    logic                dec_is_jump;
    logic                dec_supported;

    // Execute to commit
    logic                ex_valid;
    logic [`XLEN-1:0]    ex_result;
    logic [`XLEN-1:0]    ex_pc;
    logic [`RADDR_W-1:0] ex_rd;
    logic                ex_wen;
    logic                ex_jump;
    logic                ex_take;

    assign in_ready = advance;  // Input accepted whenever the pipeline moves

    inst_decode inst_decode_inst (
        .clk           (clk),
        .rst           (rst),
        .advance       (advance),
        .in_valid      (in_valid),
        .inst          (inst),
        .pc            (pc),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .dec_valid     (dec_valid),
        .dec_alu_op    (dec_alu_op),
        .dec_branch    (dec_branch),
        .dec_opa       (dec_opa),
        .dec_opb       (dec_opb),
        .dec_pc        (dec_pc),
        .dec_rs2       (dec_rs2),
        .dec_rd        (dec_rd),
        .dec_wen       (dec_wen),
        .dec_is_jump   (dec_is_jump),
        .dec_supported (dec_supported)
    );

    alu_execute alu_execute_inst (
        .clk           (clk),
        .rst           (rst),
        .advance       (advance),
        .dec_valid     (dec_valid),
        .dec_alu_op    (dec_alu_op),
        .dec_branch    (dec_branch),
        .dec_opa       (dec_opa),
        .dec_opb       (dec_opb),
        .dec_rs2       (dec_rs2),
        .dec_pc        (dec_pc),
        .dec_rd        (dec_rd),
        .dec_wen       (dec_wen),
        .dec_is_jump   (dec_is_jump),
        .dec_supported (dec_supported),
        .ex_valid      (ex_valid),
        .ex_result     (ex_result),
        .ex_pc         (ex_pc),
        .ex_rd         (ex_rd),
        .ex_wen        (ex_wen),
        .ex_jump       (ex_jump),
        .ex_take       (ex_take)
    );

    commit_stage commit_stage_inst (
        .clk          (clk),
        .rst          (rst),
        .out_ready    (out_ready),
        .ex_valid     (ex_valid),
        .ex_result    (ex_result),
        .ex_pc        (ex_pc),
        .ex_rd        (ex_rd),
        .ex_wen       (ex_wen),
        .ex_jump      (ex_jump),
        .ex_take      (ex_take),
        .advance      (advance),
        .out_valid    (out_valid),
        .rd           (rd),
        .rd_wen       (rd_wen),
        .rd_data      (rd_data),
        .branch_taken (branch_taken),
        .next_pc      (next_pc)
    );

endmodule

//--- include/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

`include "rv_exec_defines.svh"

// Packed high to low as rd, rd_wen, rd_data, branch_taken, next_pc
function automatic logic [`RADDR_W+2*`XLEN+1:0] expected_result(
    input logic [`XLEN-1:0] inst_word,
    input logic [`XLEN-1:0] pc_val,
    input logic [`XLEN-1:0] rs1,
    input logic [`XLEN-1:0] rs2
);
    logic [6:0]       opc;
    logic [2:0]       f3;
    logic             alt;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] opb;
    logic [`XLEN-1:0] data;
    logic [`XLEN-1:0] seq;
    logic [`XLEN-1:0] npc;
    logic             wen;
    logic             taken;

    opc   = inst_word[6:0];
    f3    = inst_word[14:12];
    alt   = inst_word[30];  // funct7 bit 5, picks sub and sra
    imm_i = {{20{inst_word[31]}}, inst_word[31:20]};
    imm_b = {{19{inst_word[31]}}, inst_word[31], inst_word[7], inst_word[30:25],
             inst_word[11:8], 1'b0};
    imm_u = {inst_word[31:12], 12'b0};
    imm_j = {{11{inst_word[31]}}, inst_word[31], inst_word[19:12], inst_word[20],
             inst_word[30:21], 1'b0};
    seq   = pc_val + `PC_STEP;
    data  = '0;
    wen   = 1'b0;
    taken = 1'b0;
    npc   = seq;

    case (opc)
        7'h33, 7'h13: begin
            opb = (opc == 7'h33) ? rs2 : imm_i;
            wen = 1'b1;
            case (f3)
                3'd0: data = (opc == 7'h33 && alt) ? rs1 - opb : rs1 + opb;
                3'd1: data = rs1 << opb[4:0];
                3'd2: data = {31'b0, $signed(rs1) < $signed(opb)};
                3'd3: data = {31'b0, rs1 < opb};
                3'd4: data = rs1 ^ opb;
                3'd5: begin
                    if (alt)
                        data = $signed(rs1) >>> opb[4:0];
                    else
                        data = rs1 >> opb[4:0];
                end
                3'd6: data = rs1 | opb;
                default: data = rs1 & opb;
            endcase
        end
        7'h37: begin
            data = imm_u;
            wen  = 1'b1;
        end
        7'h17: begin
            data = pc_val + imm_u;
            wen  = 1'b1;
        end
        7'h6f: begin
            data  = seq;
            wen   = 1'b1;
            taken = 1'b1;
            npc   = pc_val + imm_j;
        end
        7'h67: begin
            if (f3 == 3'd0) begin
                data  = seq;
                wen   = 1'b1;
                taken = 1'b1;
                npc   = (rs1 + imm_i) & ~32'h1;  // Target always even
            end
        end
        7'h63: begin
            case (f3)
                3'd0: taken = (rs1 == rs2);
                3'd1: taken = (rs1 != rs2);
                3'd4: taken = ($signed(rs1) < $signed(rs2));
                3'd5: taken = ($signed(rs1) >= $signed(rs2));
                3'd6: taken = (rs1 < rs2);
                3'd7: taken = (rs1 >= rs2);
                default: taken = 1'b0;
            endcase
            if (taken)
                npc = pc_val + imm_b;
        end
        default: begin
        end
    endcase

    wen = wen && (inst_word[11:7] != 5'd0);  // x0 is never written
    return {inst_word[11:7], wen, data, taken, npc};
endfunction

`endif

//--- test/tb_rv_exec_unit.sv
`timescale 1ns/1ps
`include "rv_exec_defines.svh"

module tb_rv_exec_unit;

    localparam int RES_W = `RADDR_W + 2 * `XLEN + 2;

    logic                clk;
    logic                rst;
    logic                in_valid;
    logic                in_ready;
    logic [`XLEN-1:0]    inst;
    logic [`XLEN-1:0]    pc;
    logic [`XLEN-1:0]    rs1_data;
    logic [`XLEN-1:0]    rs2_data;
    logic                out_valid;
    logic                out_ready;
    logic [`RADDR_W-1:0] rd;
    logic                rd_wen;
    logic [`XLEN-1:0]    rd_data;
    logic                branch_taken;
    logic [`XLEN-1:0]    next_pc;

    integer              seed;
    int                  errors = 0;
    int                  checked = 0;
    int                  stim_count = 0;
    logic [`XLEN-1:0]    stim_inst[$];
    logic [`XLEN-1:0]    stim_pc[$];
    logic [`XLEN-1:0]    stim_rs1[$];
    logic [`XLEN-1:0]    stim_rs2[$];
    logic [RES_W-1:0]    expected[$];
    logic [RES_W-1:0]    want;

    // Output snapshot taken while the consumer stalls
    logic                held = 1'b0;
    logic [`RADDR_W-1:0] held_rd;
    logic                held_wen;
    logic [`XLEN-1:0]    held_data;
    logic                held_taken;
    logic [`XLEN-1:0]    held_npc;

    rv_exec_unit rv_exec_unit_inst (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .inst         (inst),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .rd           (rd),
        .rd_wen       (rd_wen),
        .rd_data      (rd_data),
        .branch_taken (branch_taken),
        .next_pc      (next_pc)
    );

`include "rv_ref_model.svh"

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [31:0] rand_pc();
        logic [31:0] r;
        r = $random(seed);
        return {r[31:2], 2'b00};
    endfunction

    task automatic push_item(input logic [31:0] i, input logic [31:0] p,
                             input logic [31:0] a, input logic [31:0] b);
        stim_inst.push_back(i);
        stim_pc.push_back(p);
        stim_rs1.push_back(a);
        stim_rs2.push_back(b);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic build_directed();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] i;
        logic [11:0] imm;
        logic [6:0]  f7;
        logic [2:0]  f3;
        for (int rep = 0; rep < 3; rep++) begin
            // All ten register operations, sub and sra last
            for (int k = 0; k < 10; k++) begin
                r  = rand_word();
                a  = rand_word();
                b  = rand_word();
                f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'b000 : 3'b101);
                f7 = (k < 8) ? 7'h00 : 7'h20;
                push_item({f7, r[24:15], f3, r[11:7], 7'h33}, rand_pc(), a, b);
            end
            for (int k = 0; k < 9; k++) begin
                r   = rand_word();
                a   = rand_word();
                b   = rand_word();
                if (rep == 0)
                    a[31] = 1'b1;  // Negative source so srai differs from srli
                f3  = (k < 8) ? 3'(k) : 3'b101;
                imm = r[31:20];
                if (f3 == 3'b001 || f3 == 3'b101)
                    imm[11:5] = (k == 8) ? 7'h20 : 7'h00;
                push_item({imm, r[19:15], f3, r[11:7], 7'h13}, rand_pc(), a, b);
            end
        end
        for (int rep = 0; rep < 4; rep++) begin
            for (int k = 0; k < 4; k++) begin
                r = rand_word();
                a = rand_word();
                b = rand_word();
                case (k)
                    0: i = {r[31:12], r[11:7], 7'h37};
                    1: i = {r[31:12], r[11:7], 7'h17};
                    2: i = {r[31:12], r[11:7], 7'h6f};
                    default: i = {r[31:20], r[19:15], 3'b000, r[11:7], 7'h67};
                endcase
                push_item(i, rand_pc(), a, b);
            end
        end
        for (int k = 0; k < 6; k++) begin
            f3 = (k < 2) ? 3'(k) : 3'(k + 2);
            for (int pair = 0; pair < 3; pair++) begin
                r = rand_word();
                a = rand_word();
                b = rand_word();
                case (pair)
                    0: b = a;
                    1: begin
                        a[31] = 1'b1;  // Signed less, unsigned greater
                        b[31] = 1'b0;
                    end
                    default: begin
                        a[31] = 1'b0;
                        b[31] = 1'b1;
                    end
                endcase
                push_item({r[31:15], f3, r[11:7], 7'h63}, rand_pc(), a, b);
            end
        end
        for (int k = 0; k < 4; k++) begin
            r = rand_word();
            a = rand_word();
            b = rand_word();
            push_item({r[31:7], 7'h03}, rand_pc(), a, b);  // Load
            push_item({7'h00, r[24:15], 3'b000, 5'd0, 7'h33}, rand_pc(), a, b);
            push_item({r[31:12], 5'd0, 7'h37}, rand_pc(), a, b);
            push_item({r[31:12], 5'd0, 7'h6f}, rand_pc(), a, b);  // Jumps but links nowhere
        end
    endtask

    task automatic build_random(input int count);
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] i;
        logic [11:0] imm;
        logic [6:0]  f7;
        logic [2:0]  f3;
        for (int n = 0; n < count; n++) begin
            r  = rand_word();
            s  = rand_word();
            a  = rand_word();
            b  = rand_word();
            f3 = r[14:12];
            case (s[2:0])
                3'd0: begin
                    f7 = (s[3] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
                    i  = {f7, r[24:15], f3, r[11:7], 7'h33};
                end
                3'd1: begin
                    imm = r[31:20];
                    if (f3 == 3'b001 || f3 == 3'b101)
                        imm[11:5] = (f3 == 3'b101 && s[3]) ? 7'h20 : 7'h00;
                    i = {imm, r[19:15], f3, r[11:7], 7'h13};
                end
                3'd2: i = {r[31:12], r[11:7], 7'h37};
                3'd3: i = {r[31:12], r[11:7], 7'h17};
                3'd4: i = {r[31:12], r[11:7], 7'h6f};
                3'd5: i = {r[31:20], r[19:15], 3'b000, r[11:7], 7'h67};
                3'd6: begin
                    if (f3[2:1] == 2'b01)
                        f3[1] = 1'b0;  // No branch uses funct3 010 or 011
                    if (s[4])
                        b = a;
                    i = {r[31:15], f3, r[11:7], 7'h63};
                end
                default: i = {r[31:7], 7'h03};
            endcase
            push_item(i, rand_pc(), a, b);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Consumer stalls about one cycle in four
    always @(negedge clk) begin
        out_ready = (rand_word() & 32'd3) != 32'd0;
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (held) begin
                compare_value("out_valid", 32'(out_valid), 32'd1);
                compare_value("rd", 32'(rd), 32'(held_rd));
                compare_value("rd_wen", 32'(rd_wen), 32'(held_wen));
                compare_value("rd_data", rd_data, held_data);
                compare_value("branch_taken", 32'(branch_taken), 32'(held_taken));
                compare_value("next_pc", next_pc, held_npc);
            end
            if (out_valid && out_ready) begin
                if (expected.size() == 0) begin
                    $display("ERROR at %0t: output accepted with no input waiting for it", $time);
                    errors++;
                end else begin
                    want = expected.pop_front();
                    compare_value("rd", 32'(rd), 32'(want[RES_W-1:2*`XLEN+2]));
                    compare_value("rd_wen", 32'(rd_wen), 32'(want[2*`XLEN+1]));
                    if (want[2*`XLEN+1])
                        compare_value("rd_data", rd_data, want[2*`XLEN:`XLEN+1]);
                    compare_value("branch_taken", 32'(branch_taken), 32'(want[`XLEN]));
                    compare_value("next_pc", next_pc, want[`XLEN-1:0]);
                    checked++;
                end
            end
            held       = out_valid && !out_ready;
            held_rd    = rd;
            held_wen   = rd_wen;
            held_data  = rd_data;
            held_taken = branch_taken;
            held_npc   = next_pc;
        end
    end

    initial begin
        wait (stim_count > 0);
        repeat (stim_count * (`PIPE_DEPTH + 8) + 4) @(posedge clk);
        $display("Timeout: run did not finish, %0d results never came out", expected.size());
        $display("Checked %0d of %0d results, %0d errors", checked, stim_count, errors + 1);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        seed      = 69198;
        rst       = 1'b1;
        in_valid  = 1'b0;
        inst      = '0;
        pc        = '0;
        rs1_data  = '0;
        rs2_data  = '0;
        out_ready = 1'b1;
        build_directed();
        build_random(150);
        stim_count = stim_inst.size();

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // in_valid stays high from the first item to the last
        for (int i = 0; i < stim_count; i++) begin
            in_valid = 1'b1;
            inst     = stim_inst[i];
            pc       = stim_pc[i];
            rs1_data = stim_rs1[i];
            rs2_data = stim_rs2[i];
            @(posedge clk);
            while (!in_ready)
                @(posedge clk);
            expected.push_back(expected_result(inst, pc, rs1_data, rs2_data));
            @(negedge clk);
        end
        in_valid = 1'b0;

        while (expected.size() != 0)
            @(posedge clk);
        repeat (`PIPE_DEPTH + 2) @(posedge clk);

        $display("Checked %0d of %0d results, %0d errors", checked, stim_count, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
hw/rv_exec_pkg.sv
hw/imm_gen.sv
hw/inst_decode.sv
hw/alu_execute.sv
hw/commit_stage.sv
hw/rv_exec_unit.sv
test/tb_rv_exec_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_rv_exec_unit -f verilog.f -o tb_rv_exec_unit

./obj_dir/tb_rv_exec_unit | tee sim.log

grep -q "RESULT: PASS" sim.log
echo "Simulation passed"
